/* rtl/fir_cfg.svh */
// filter size, bus widths and register map, included by the packages and the RTL
`ifndef FIR_CFG_SVH
`define FIR_CFG_SVH

// number of filter taps, also the MAC cycles per output
`define FIR_NUM_TAPS 11

// sample, coefficient and AXI-lite data width
`define FIR_DATA_W 32

// AXI-lite byte address width
`define FIR_ADDR_W 12

// width of the block length register and sample counter
`define FIR_CNT_W 16

// register map
// ap_ctrl block control
`define FIR_ADDR_CTRL 12'h000
// number of samples in a block
`define FIR_ADDR_LEN 12'h010
// first coefficient, tap i at TAP0 + 4*i
`define FIR_ADDR_TAP0 12'h020

`endif

/* rtl/fir_data_pkg.sv */
// datapath types shared by the filter engine, the register file and the top level
`include "fir_cfg.svh"

package fir_data_pkg;

    // one stream sample, two's complement
    typedef logic signed [`FIR_DATA_W-1:0] sample_t;

    // one tap coefficient, two's complement
    typedef logic signed [`FIR_DATA_W-1:0] coef_t;

    // tap number or ring slot, 0 to 10
    typedef logic [3:0] tap_idx_t;

    // samples per block
    typedef logic [`FIR_CNT_W-1:0] sample_cnt_t;

endpackage

/* rtl/fir_reg_pkg.sv */
// AXI-lite register access types and ap_ctrl bit layout for the bus slave and register file
`include "fir_cfg.svh"

package fir_reg_pkg;

    // byte address on the AXI-lite bus
    typedef logic [`FIR_ADDR_W-1:0] reg_addr_t;

    // one AXI-lite data word
    typedef logic [`FIR_DATA_W-1:0] reg_data_t;

    // ap_ctrl bits
    // written 1 by software to launch a block
    localparam int AP_START_BIT = 0;
    // set when the last output is taken, cleared on read
    localparam int AP_DONE_BIT  = 1;
    // high while no block is running
    localparam int AP_IDLE_BIT  = 2;

    // bus slave states
    // AXIL_IDLE also covers the arready cycle
    typedef enum logic [1:0] {
        AXIL_IDLE,
        AXIL_RD_RESP,
        AXIL_WR_DONE
    } axil_state_e;

endpackage

/* rtl/axil_slave.sv */
// AXI-lite slave without write response, turns bus transfers into register file accesses
`timescale 1ns/1ps

module axil_slave
    import fir_reg_pkg::*;
(
    input  logic      axis_clk,
    input  logic      axis_rst_n,
    // write address and data
    input  logic      awvalid,
    output logic      awready,
    input  reg_addr_t awaddr,
    input  logic      wvalid,
    output logic      wready,
    input  reg_data_t wdata,
    // read address and data
    input  logic      arvalid,
    output logic      arready,
    input  reg_addr_t araddr,
    output logic      rvalid,
    input  logic      rready,
    output reg_data_t rdata,
    // register file side
    output logic      reg_wr_en,
    output logic      reg_rd_en,
    output reg_addr_t reg_addr,
    output reg_data_t reg_wdata,
    input  reg_data_t reg_rdata
);

    axil_state_e state_q;
    axil_state_e state_d;
    logic        arready_q;
    logic        wr_req;
    logic        wr_done;

    // address and data paired, both must be valid
    assign wr_req  = awvalid && wvalid;
    assign wr_done = (state_q == AXIL_WR_DONE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            AXIL_IDLE: begin
                // read address taken this cycle
                if (arready_q) begin
                    state_d = AXIL_RD_RESP;
                end else if (wr_req) begin
                    state_d = AXIL_WR_DONE;
                end
            end
            // ready pulse lasts one cycle
            AXIL_WR_DONE: begin
                state_d = AXIL_IDLE;
            end
            // hold the response until the master takes it
            AXIL_RD_RESP: begin
                if (rready) begin
                    state_d = AXIL_IDLE;
                end
            end
            default: begin
                state_d = AXIL_IDLE;
            end
        endcase
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state_q   <= AXIL_IDLE;
            arready_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            // write wins over read in the same idle cycle
            arready_q <= (state_q == AXIL_IDLE) && !arready_q && arvalid && !wr_req;
        end
    end

    // capture readback on the address handshake, stable while rvalid
    always_ff @(posedge axis_clk) begin
        if (reg_rd_en) begin
            rdata <= reg_rdata;
        end
    end

    assign awready = wr_done;
    assign wready  = wr_done;
    assign arready = arready_q;
    assign rvalid  = (state_q == AXIL_RD_RESP);

    // register write lands on the ready edge
    assign reg_wr_en = wr_done;
    assign reg_rd_en = arready_q;
    assign reg_addr  = wr_done ? awaddr : araddr;
    assign reg_wdata = wdata;

endmodule

/* rtl/fir_regs.sv */
// register file with ap_ctrl, block length and tap coefficients plus readback decode
`timescale 1ns/1ps
`include "fir_cfg.svh"

module fir_regs
    import fir_data_pkg::*, fir_reg_pkg::*;
(
    input  logic        axis_clk,
    input  logic        axis_rst_n,
    // bus slave side
    input  logic        reg_wr_en,
    input  logic        reg_rd_en,
    input  reg_addr_t   reg_addr,
    input  reg_data_t   reg_wdata,
    output reg_data_t   reg_rdata,
    // engine side
    input  logic        start_ack,
    input  logic        block_done,
    output logic        ap_start,
    output sample_cnt_t data_length,
    output coef_t       taps [`FIR_NUM_TAPS]
);

    // first byte past the tap window
    localparam reg_addr_t TAP_END = reg_addr_t'(`FIR_ADDR_TAP0 + 4 * `FIR_NUM_TAPS);

    logic      ap_done;
    logic      ap_idle;
    logic      ctrl_hit;
    logic      len_hit;
    logic      tap_hit;
    reg_addr_t tap_off;
    tap_idx_t  tap_sel;

    // address decode
    assign ctrl_hit = (reg_addr == `FIR_ADDR_CTRL);
    assign len_hit  = (reg_addr == `FIR_ADDR_LEN);
    assign tap_hit  = (reg_addr >= `FIR_ADDR_TAP0) && (reg_addr < TAP_END) &&
                      (reg_addr[1:0] == 2'b00);
    assign tap_off  = reg_addr - `FIR_ADDR_TAP0;
    assign tap_sel  = tap_idx_t'(tap_off >> 2);

    // ap_ctrl, later assignments take priority
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ap_start <= 1'b0;
            ap_done  <= 1'b0;
            ap_idle  <= 1'b1;
        end else begin
            // start only accepted while idle
            if (reg_wr_en && ctrl_hit && reg_wdata[AP_START_BIT] && ap_idle) begin
                ap_start <= 1'b1;
            end
            // done is read-to-clear
            if (reg_rd_en && ctrl_hit) begin
                ap_done <= 1'b0;
            end
            // engine picked up the start
            if (start_ack) begin
                ap_start <= 1'b0;
                ap_idle  <= 1'b0;
            end
            // last output left the stream port
            if (block_done) begin
                ap_done <= 1'b1;
                ap_idle <= 1'b1;
            end
        end
    end

    // block length, locked while busy
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            data_length <= '0;
        end else if (reg_wr_en && len_hit && ap_idle) begin
            data_length <= sample_cnt_t'(reg_wdata);
        end
    end

    // coefficients, locked while busy
    always_ff @(posedge axis_clk) begin
        if (reg_wr_en && tap_hit && ap_idle) begin
            taps[tap_sel] <= coef_t'(reg_wdata);
        end
    end

    // readback mux, unmapped reads 0
    always_comb begin
        reg_rdata = '0;
        if (ctrl_hit) begin
            reg_rdata[AP_START_BIT] = ap_start;
            reg_rdata[AP_DONE_BIT]  = ap_done;
            reg_rdata[AP_IDLE_BIT]  = ap_idle;
        end else if (len_hit) begin
            reg_rdata = reg_data_t'(data_length);
        end else if (tap_hit) begin
            reg_rdata = reg_data_t'(taps[tap_sel]);
        end
    end

endmodule

/* rtl/fir_engine.sv */
// FIR datapath with one multiplier and one adder, sample ring and stream output register
`timescale 1ns/1ps
`include "fir_cfg.svh"

module fir_engine
    import fir_data_pkg::*;
(
    input  logic        axis_clk,
    input  logic        axis_rst_n,
    // block control
    input  logic        ap_start,
    input  sample_cnt_t data_length,
    input  coef_t       taps [`FIR_NUM_TAPS],
    output logic        start_ack,
    output logic        block_done,
    // stream in
    input  logic        ss_tvalid,
    output logic        ss_tready,
    input  sample_t     ss_tdata,
    // stream out
    output logic        sm_tvalid,
    input  logic        sm_tready,
    output sample_t     sm_tdata,
    output logic        sm_tlast
);

    localparam tap_idx_t LAST_TAP  = tap_idx_t'(`FIR_NUM_TAPS - 1);
    localparam tap_idx_t RING_WRAP = tap_idx_t'(`FIR_NUM_TAPS);

    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_WAIT,
        ENG_MAC,
        ENG_STORE
    } eng_state_e;

    eng_state_e  state_q;
    eng_state_e  state_d;
    sample_t     ring_q [`FIR_NUM_TAPS];
    // slot holding the newest sample
    tap_idx_t    head_q;
    tap_idx_t    head_next;
    tap_idx_t    mac_k;
    tap_idx_t    mac_idx;
    sample_t     acc;
    sample_t     prod;
    sample_t     acc_sum;
    sample_t     out_data;
    sample_cnt_t out_cnt;
    logic        start_go;
    logic        ss_hs;
    logic        out_free;
    logic        last_res;
    logic        load_out;

    assign start_go  = (state_q == ENG_IDLE) && ap_start;
    // accept a sample even with a result parked in the output register
    assign ss_tready = (state_q == ENG_WAIT);
    assign ss_hs     = ss_tvalid && ss_tready;
    assign head_next = (head_q == LAST_TAP) ? tap_idx_t'(0) : head_q + 1'b1;

    // slot k samples back, mod 11
    assign mac_idx = (head_q >= mac_k) ? head_q - mac_k : head_q + RING_WRAP - mac_k;
    // low 32 bits of the product, wrap on add
    assign prod    = sample_t'(taps[mac_k] * ring_q[mac_idx]);
    assign acc_sum = acc + prod;

    // output register empty or draining this cycle
    assign out_free = !sm_tvalid || sm_tready;
    assign last_res = (out_cnt + sample_cnt_t'(1)) == data_length;

    always_comb begin
        state_d  = state_q;
        load_out = 1'b0;
        out_data = acc_sum;
        case (state_q)
            ENG_IDLE: begin
                if (ap_start) begin
                    state_d = ENG_WAIT;
                end
            end
            ENG_WAIT: begin
                if (ss_tvalid) begin
                    state_d = ENG_MAC;
                end
            end
            ENG_MAC: begin
                // final tap, result goes straight out if there is room
                if (mac_k == LAST_TAP) begin
                    if (out_free) begin
                        load_out = 1'b1;
                        state_d  = last_res ? ENG_IDLE : ENG_WAIT;
                    end else begin
                        state_d = ENG_STORE;
                    end
                end
            end
            ENG_STORE: begin
                // stalled result sits in acc
                out_data = acc;
                if (out_free) begin
                    load_out = 1'b1;
                    state_d  = last_res ? ENG_IDLE : ENG_WAIT;
                end
            end
            default: begin
                state_d = ENG_IDLE;
            end
        endcase
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state_q    <= ENG_IDLE;
            head_q     <= '0;
            mac_k      <= '0;
            out_cnt    <= '0;
            start_ack  <= 1'b0;
            block_done <= 1'b0;
            sm_tvalid  <= 1'b0;
            sm_tlast   <= 1'b0;
        end else begin
            state_q    <= state_d;
            start_ack  <= start_go;
            // pulse after the tlast beat is taken
            block_done <= sm_tvalid && sm_tready && sm_tlast;
            if (start_go) begin
                head_q  <= '0;
                out_cnt <= '0;
            end else if (ss_hs) begin
                head_q <= head_next;
            end
            // tap walk 0 to 10
            if (ss_hs) begin
                mac_k <= '0;
            end else if (state_q == ENG_MAC && mac_k != LAST_TAP) begin
                mac_k <= mac_k + 1'b1;
            end
            // one-entry output register
            if (load_out) begin
                sm_tvalid <= 1'b1;
                sm_tlast  <= last_res;
                out_cnt   <= out_cnt + sample_cnt_t'(1);
            end else if (sm_tready) begin
                sm_tvalid <= 1'b0;
            end
        end
    end

    // accumulator and output data
    always_ff @(posedge axis_clk) begin
        if (ss_hs) begin
            acc <= '0;
        end else if (state_q == ENG_MAC) begin
            acc <= acc_sum;
        end
        if (load_out) begin
            sm_tdata <= out_data;
        end
    end

    // history cleared at block start so earlier blocks read as 0
    always_ff @(posedge axis_clk) begin
        if (start_go) begin
            for (int i = 0; i < `FIR_NUM_TAPS; i++) begin
                ring_q[i] <= '0;
            end
        end else if (ss_hs) begin
            ring_q[head_next] <= ss_tdata;
        end
    end

endmodule

/* rtl/fir_top.sv */
// FIR filter top level joining the AXI-lite slave, register file and filter engine
`timescale 1ns/1ps
`include "fir_cfg.svh"

module fir_top
    import fir_data_pkg::*, fir_reg_pkg::*;
(
    input  logic      axis_clk,
    input  logic      axis_rst_n,
    // AXI-lite
    input  logic      awvalid,
    output logic      awready,
    input  reg_addr_t awaddr,
    input  logic      wvalid,
    output logic      wready,
    input  reg_data_t wdata,
    input  logic      arvalid,
    output logic      arready,
    input  reg_addr_t araddr,
    output logic      rvalid,
    input  logic      rready,
    output reg_data_t rdata,
    // AXI-stream in
    input  logic      ss_tvalid,
    output logic      ss_tready,
    input  sample_t   ss_tdata,
    // AXI-stream out
    output logic      sm_tvalid,
    input  logic      sm_tready,
    output sample_t   sm_tdata,
    output logic      sm_tlast
);

    // bus slave to register file
    logic        reg_wr_en;
    logic        reg_rd_en;
    reg_addr_t   reg_addr;
    reg_data_t   reg_wdata;
    reg_data_t   reg_rdata;
    // register file to engine
    logic        ap_start;
    logic        start_ack;
    logic        block_done;
    sample_cnt_t data_length;
    coef_t       taps [`FIR_NUM_TAPS];

    axil_slave axil_i (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .reg_wr_en  (reg_wr_en),
        .reg_rd_en  (reg_rd_en),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata)
    );

    fir_regs regs_i (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .reg_wr_en   (reg_wr_en),
        .reg_rd_en   (reg_rd_en),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata),
        .start_ack   (start_ack),
        .block_done  (block_done),
        .ap_start    (ap_start),
        .data_length (data_length),
        .taps        (taps)
    );

    fir_engine engine_i (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .ap_start    (ap_start),
        .data_length (data_length),
        .taps        (taps),
        .start_ack   (start_ack),
        .block_done  (block_done),
        .ss_tvalid   (ss_tvalid),
        .ss_tready   (ss_tready),
        .ss_tdata    (ss_tdata),
        .sm_tvalid   (sm_tvalid),
        .sm_tready   (sm_tready),
        .sm_tdata    (sm_tdata),
        .sm_tlast    (sm_tlast)
    );

endmodule

/* test/fir_sva.sv */
// protocol assertions for the FIR top level, attached to fir_top by the bind at the bottom
`timescale 1ns/1ps

module fir_sva
    import fir_data_pkg::*;
(
    input logic    axis_clk,
    input logic    axis_rst_n,
    input logic    awvalid,
    input logic    wvalid,
    input logic    awready,
    input logic    wready,
    input logic    rvalid,
    input logic    rready,
    input logic    ss_tready,
    input logic    sm_tvalid,
    input logic    sm_tready,
    input sample_t sm_tdata,
    input logic    ap_start
);

    // set once software has launched a block
    logic started;
    // failed assertions so far
    int unsigned fail_count = 0;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            started <= 1'b0;
        end else if (ap_start) begin
            started <= 1'b1;
        end
    end

    // write ready pulse pairs with wready, needs both valids and lasts one cycle
    assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        awready |-> wready && awvalid && wvalid ##1 !awready)
        else begin
            fail_count++;
            $error("write ready unpaired, without both valids or longer than one cycle");
        end

    // read response held until taken
    assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        rvalid && !rready |=> rvalid)
        else begin
            fail_count++;
            $error("rvalid dropped before rready");
        end

    // output beat frozen under back-pressure
    assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata))
        else begin
            fail_count++;
            $error("sm_tvalid or sm_tdata changed while stalled");
        end

    // no sample accepted before the first start
    assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        ss_tready |-> started)
        else begin
            fail_count++;
            $error("ss_tready high before ap_start");
        end

endmodule

bind fir_top fir_sva sva_i (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .awvalid    (awvalid),
    .wvalid     (wvalid),
    .awready    (awready),
    .wready     (wready),
    .rvalid     (rvalid),
    .rready     (rready),
    .ss_tready  (ss_tready),
    .sm_tvalid  (sm_tvalid),
    .sm_tready  (sm_tready),
    .sm_tdata   (sm_tdata),
    .ap_start   (ap_start)
);

/* test/tb_fir.sv */
// directed testbench for the FIR filter, drives AXI-lite and the streams against a model
`timescale 1ns/1ps
`include "fir_cfg.svh"

module tb_fir
    import fir_data_pkg::*, fir_reg_pkg::*;
();

    localparam int BLOCK_LEN      = 20;
    localparam int NUM_TAPS       = `FIR_NUM_TAPS;
    // three blocks of 20 at about 12 cycles each, plus stall gaps and margin
    localparam int TIMEOUT_CYCLES = 4000;

    logic      axis_clk;
    logic      axis_rst_n;
    logic      awvalid;
    logic      awready;
    reg_addr_t awaddr;
    logic      wvalid;
    logic      wready;
    reg_data_t wdata;
    logic      arvalid;
    logic      arready;
    reg_addr_t araddr;
    logic      rvalid;
    logic      rready;
    reg_data_t rdata;
    logic      ss_tvalid;
    logic      ss_tready;
    sample_t   ss_tdata;
    logic      sm_tvalid;
    logic      sm_tready;
    sample_t   sm_tdata;
    logic      sm_tlast;

    // model state and captured outputs
    coef_t   tap_val  [NUM_TAPS];
    sample_t x_val    [BLOCK_LEN];
    sample_t got_data [BLOCK_LEN];
    logic    got_last [BLOCK_LEN];
    integer  seed;
    int      errors = 0;
    int      checks = 0;
    int      cycles = 0;

    fir_top dut_i (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .ss_tvalid  (ss_tvalid),
        .ss_tready  (ss_tready),
        .ss_tdata   (ss_tdata),
        .sm_tvalid  (sm_tvalid),
        .sm_tready  (sm_tready),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast)
    );

    // 4 ns period
    always #2 axis_clk = ~axis_clk;

    // run limit
    always @(posedge axis_clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("error: %s expected %h actual %h", test, expected, actual);
    endtask

    task automatic report_failure(input string test, input string what);
        errors++;
        $display("%s: %s", test, what);
    endtask

    // sum of tap k times x[n-k] in 32-bit wrap arithmetic
    function automatic sample_t model_output(input int n);
        sample_t sum;
        sum = '0;
        for (int k = 0; k < NUM_TAPS; k++) begin
            // samples before the block start count as zero
            if (n - k >= 0) begin
                sum = sum + tap_val[k] * x_val[n - k];
            end
        end
        return sum;
    endfunction

    // address and data held until the ready pulse
    task automatic axil_write(input reg_addr_t addr, input reg_data_t data);
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = addr;
        wdata   = data;
        @(negedge axis_clk);
        while (!awready) @(negedge axis_clk);
        @(posedge axis_clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic axil_read(input reg_addr_t addr, output reg_data_t data);
        arvalid = 1'b1;
        araddr  = addr;
        @(negedge axis_clk);
        while (!arready) @(negedge axis_clk);
        @(posedge axis_clk);
        #1;
        arvalid = 1'b0;
        // response arrives a cycle after the address
        @(negedge axis_clk);
        while (!rvalid) @(negedge axis_clk);
        // response left waiting one cycle before rready
        @(posedge axis_clk);
        #1;
        rready = 1'b1;
        @(negedge axis_clk);
        data = rdata;
        @(posedge axis_clk);
        #1;
        rready = 1'b0;
    endtask

    task automatic wait_stream_ready();
        @(negedge axis_clk);
        while (!ss_tready) @(negedge axis_clk);
        @(posedge axis_clk);
        #1;
    endtask

    task automatic send_samples(input int count);
        for (int i = 0; i < count; i++) begin
            ss_tvalid = 1'b1;
            ss_tdata  = x_val[i];
            @(negedge axis_clk);
            while (!ss_tready) @(negedge axis_clk);
            @(posedge axis_clk);
            #1;
        end
        ss_tvalid = 1'b0;
    endtask

    // optional random tready gaps long enough to stall a finished MAC
    task automatic collect_outputs(input int count, input bit gaps);
        int gap;
        for (int i = 0; i < count; i++) begin
            if (gaps) begin
                gap       = $unsigned($random(seed)) % 24;
                sm_tready = 1'b0;
                repeat (gap) begin
                    @(posedge axis_clk);
                    #1;
                end
            end
            sm_tready = 1'b1;
            @(negedge axis_clk);
            while (!sm_tvalid) @(negedge axis_clk);
            got_data[i] = sm_tdata;
            got_last[i] = sm_tlast;
            @(posedge axis_clk);
            #1;
        end
    endtask

    task automatic program_taps();
        for (int k = 0; k < NUM_TAPS; k++) begin
            tap_val[k] = $random(seed);
            axil_write(reg_addr_t'(`FIR_ADDR_TAP0 + 4 * k), tap_val[k]);
        end
    endtask

    task automatic test_reset();
        reg_data_t rd;
        checks++;
        if (sm_tvalid !== 1'b0 || ss_tready !== 1'b0) begin
            report_failure("reset", "stream valid or ready is high after reset");
        end
        axil_read(`FIR_ADDR_CTRL, rd);
        checks++;
        if (rd !== 32'h4) report_mismatch("reset", 32'h4, rd);
    endtask

    task automatic test_reg_access();
        reg_data_t rd;
        program_taps();
        axil_write(`FIR_ADDR_LEN, BLOCK_LEN);
        for (int k = 0; k < NUM_TAPS; k++) begin
            axil_read(reg_addr_t'(`FIR_ADDR_TAP0 + 4 * k), rd);
            checks++;
            if (rd !== tap_val[k]) begin
                report_mismatch($sformatf("reg_access tap%0d", k), tap_val[k], rd);
            end
        end
        axil_read(`FIR_ADDR_LEN, rd);
        checks++;
        if (rd !== BLOCK_LEN) report_mismatch("reg_access len", BLOCK_LEN, rd);
        // gaps in the map
        axil_read(12'h004, rd);
        checks++;
        if (rd !== 32'h0) report_mismatch("reg_access unmapped", 32'h0, rd);
        axil_read(12'h100, rd);
        checks++;
        if (rd !== 32'h0) report_mismatch("reg_access unmapped", 32'h0, rd);
    endtask

    // one block of fresh samples checked against the model
    task automatic run_block(input string test, input bit gaps, input bit busy_checks);
        reg_data_t rd;
        sample_t   exp_data;
        for (int i = 0; i < BLOCK_LEN; i++) begin
            x_val[i] = $random(seed);
        end
        axil_write(`FIR_ADDR_CTRL, reg_data_t'(1) << AP_START_BIT);
        // engine asks for samples once it has taken the start
        wait_stream_ready();
        if (busy_checks) begin
            axil_read(`FIR_ADDR_CTRL, rd);
            checks++;
            if (rd !== 32'h0) report_mismatch("busy_ctrl", 32'h0, rd);
            // locked coefficient
            axil_write(`FIR_ADDR_TAP0, ~tap_val[0]);
            axil_read(`FIR_ADDR_TAP0, rd);
            checks++;
            if (rd !== tap_val[0]) report_mismatch("busy_ctrl tap0", tap_val[0], rd);
        end
        fork
            send_samples(BLOCK_LEN);
            collect_outputs(BLOCK_LEN, gaps);
        join
        for (int i = 0; i < BLOCK_LEN; i++) begin
            exp_data = model_output(i);
            checks++;
            if (got_data[i] !== exp_data) begin
                report_mismatch($sformatf("%s out%0d", test, i), exp_data, got_data[i]);
            end
            checks++;
            if (got_last[i] !== (i == BLOCK_LEN - 1)) begin
                report_mismatch($sformatf("%s tlast%0d", test, i), i == BLOCK_LEN - 1,
                                got_last[i]);
            end
        end
        // done and idle, then done read-cleared
        axil_read(`FIR_ADDR_CTRL, rd);
        checks++;
        if (rd !== 32'h6) report_mismatch($sformatf("%s ctrl", test), 32'h6, rd);
        axil_read(`FIR_ADDR_CTRL, rd);
        checks++;
        if (rd !== 32'h4) report_mismatch($sformatf("%s ctrl", test), 32'h4, rd);
        checks++;
        if (sm_tvalid !== 1'b0) begin
            report_failure(test, "an extra output appeared after the block");
        end
    endtask

    initial begin
        seed       = 51691;
        axis_clk   = 1'b0;
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        sm_tready  = 1'b0;
        repeat (4) @(posedge axis_clk);
        #1;
        axis_rst_n = 1'b1;

        test_reset();
        test_reg_access();
        run_block("block_stream", 1'b0, 1'b0);
        run_block("backpressure", 1'b1, 1'b1);
        // earlier samples must not leak into this block
        run_block("history_clear", 1'b1, 1'b0);

        $display("summary: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, dut_i.sva_i.fail_count);
        if (errors == 0 && dut_i.sva_i.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+rtl
rtl/fir_data_pkg.sv
rtl/fir_reg_pkg.sv
rtl/axil_slave.sv
rtl/fir_regs.sv
rtl/fir_engine.sv
rtl/fir_top.sv
test/fir_sva.sv
test/tb_fir.sv

/* Bender.yml */
package:
  name: fir_filter

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/fir_data_pkg.sv
      - rtl/fir_reg_pkg.sv
      - rtl/axil_slave.sv
      - rtl/fir_regs.sv
      - rtl/fir_engine.sv
      - rtl/fir_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/fir_sva.sv
      - test/tb_fir.sv
